// File: all.f
+incdir+source
+incdir+verification
source/alu_types_pkg.sv
source/alu_state_pkg.sv
source/alu_unit_if.sv
source/frac_multiplier.sv
source/restoring_divider.sv
source/alu_dispatch.sv
source/super_alu.sv
verification/super_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the ALU testbench with Verilator, run it and decide from the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module super_alu_tb -Mdir obj_dir -o super_alu_sim &&
    ./obj_dir/super_alu_sim > sim.log 2>&1

grep -qx "Testbench passed" sim.log && echo "simulation ok" ||
    { echo "simulation failed, see sim.log"; exit 1; }

// File: source/alu_consts.svh
//////////////////////////////////////////////////
// widths and iteration counts of the shared ALU
// included by the type package and the two arithmetic units
//////////////////////////////////////////////////

`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result word
`define ALU_DATA_W 13

// binary fraction of the multiplier operand
`define ALU_FRAC_W 8

`define ALU_QUOT_W 9    // divider quotient bits, one per iteration

`define ALU_CNT_W 4     // iteration counter, covers 0..9

`endif

// File: source/alu_dispatch.sv
//////////////////////////////////////////////////
// starts the unit named by the op code and returns its result
// adds no cycle, result and done pass through combinationally
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_dispatch (
    input  logic                      alu_start,
    input  alu_types_pkg::alu_op_e    alu_type,
    input  alu_types_pkg::alu_mode_t  mode_type,
    input  alu_types_pkg::alu_data_t  x_in,
    input  alu_types_pkg::alu_data_t  y_in,
    alu_unit_if.ctrl                  mul_bus,
    alu_unit_if.ctrl                  div_bus,
    output alu_types_pkg::alu_data_t  fout,
    output logic                      alu_is_done
);
    logic mul_sel;  // op code names the multiplier
    logic div_sel;

    // exact compare, so op_sqrt and non one-hot codes select nothing
    assign mul_sel = (alu_type == alu_types_pkg::op_mul);
    assign div_sel = (alu_type == alu_types_pkg::op_div);

    //////////////////////////////////////////////////
    // requests
    assign mul_bus.start = alu_start & mul_sel;
    assign div_bus.start = alu_start & div_sel;

    // operands and mode go to both, only the started unit samples them
    assign mul_bus.mode = mode_type;
    assign mul_bus.x    = x_in;
    assign mul_bus.y    = y_in;
    assign div_bus.mode = mode_type;
    assign div_bus.x    = x_in;
    assign div_bus.y    = y_in;

    //////////////////////////////////////////////////
    // result select
    always_comb begin
        if (mul_sel) begin
            fout        = mul_bus.result;
            alu_is_done = mul_bus.done;
        end else if (div_sel) begin
            fout        = div_bus.result;
            alu_is_done = div_bus.done;
        end else begin
            fout        = '0;    // unstarted code
            alu_is_done = 1'b0;
        end
    end

    // at most one unit runs at a time
    a_one_start: assert property (@(posedge mul_bus.CLK) disable iff (!mul_bus.RST_N)
        !(mul_bus.start && div_bus.start))
        else $error("multiplier and divider started together");

endmodule

// File: source/alu_state_pkg.sv
//////////////////////////////////////////////////
// FSM states of the multiplier and the divider
//////////////////////////////////////////////////

package alu_state_pkg;

    // multiplier sequencing
    typedef enum logic [1:0] {
        mul_idle = 2'd0,    // waiting for start
        mul_run  = 2'd1,    // shift-and-add steps, then finish
        mul_done = 2'd2     // result held until start drops
    } mul_state_e;

    // divider sequencing
    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1,    // restoring steps, then finish
        div_done = 2'd2
    } div_state_e;

endpackage

// File: source/alu_types_pkg.sv
//////////////////////////////////////////////////
// data, operation code and mode types of the ALU
// shared by the top level, the dispatcher and both units
//////////////////////////////////////////////////

`include "alu_consts.svh"

package alu_types_pkg;

    //////////////////////////////////////////////////
    // operation select, one-hot
    typedef enum logic [2:0] {
        op_mul  = 3'b100,
        op_div  = 3'b010,
        op_sqrt = 3'b001    // reserved, starts no unit
    } alu_op_e;

    // multiplier modes, code 3 runs as mul_max
    typedef enum logic [1:0] {
        mul_pure = 2'd0,    // floor(x*y/256)
        mul_frac = 2'd1,    // floor(x*y/256) + x
        mul_max  = 2'd2     // 2x without iterating
    } mul_mode_e;

    // divider modes, code 3 runs as div_sa
    typedef enum logic [1:0] {
        div_sa  = 2'd0,     // x << 8
        div_t27 = 2'd1,     // x << 7
        div_t36 = 2'd2      // x << 6
    } div_mode_e;

    //////////////////////////////////////////////////
    typedef logic [1:0]             alu_mode_t;     // raw mode field
    typedef logic [`ALU_DATA_W-1:0] alu_data_t;     // operand and result
    typedef logic [`ALU_QUOT_W-1:0] alu_quot_t;     // divider quotient

endpackage

// File: source/alu_unit_if.sv
//////////////////////////////////////////////////
// link between the dispatcher and one arithmetic unit
// start is a level, done stays up while start stays up
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface alu_unit_if (
    input logic CLK,
    input logic RST_N
);
    logic                     start;   // level request from the dispatcher
    alu_types_pkg::alu_mode_t mode;    // raw mode, decoded by the unit
    alu_types_pkg::alu_data_t x;
    alu_types_pkg::alu_data_t y;
    alu_types_pkg::alu_data_t result;  // zero while idle
    logic                     done;

    // dispatcher side, clock and reset only for its checks
    modport ctrl (
        input  CLK, RST_N,
        output start, mode, x, y,
        input  result, done
    );

    modport unit (
        input  start, mode, x, y,
        output result, done
    );

endinterface

// File: source/frac_multiplier.sv
//////////////////////////////////////////////////
// shift-and-add multiplier with an 8-bit fraction operand
// one load edge, 8 add steps and one finish edge
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_consts.svh"

module frac_multiplier (
    input  logic     CLK,
    input  logic     RST_N,
    alu_unit_if.unit bus
);
    localparam int ACC_W = `ALU_DATA_W + `ALU_FRAC_W;   // full x*y product
    localparam logic [`ALU_CNT_W-1:0] FRAC_STEPS = `ALU_FRAC_W;

    alu_state_pkg::mul_state_e state;
    logic [`ALU_CNT_W-1:0]     cnt;        // add steps left
    logic                      done_q;
    alu_types_pkg::alu_data_t  result_q;

    alu_types_pkg::alu_data_t  x_q;        // multiplicand copy
    logic [`ALU_FRAC_W-1:0]    frac_q;     // fraction, lsb is the current bit
    logic [ACC_W-1:0]          acc;
    logic                      add_x;      // frac mode adds x at the finish

    logic                      load;
    logic                      iterate;
    logic                      is_frac;
    logic                      is_max;
    logic [`ALU_CNT_W-1:0]     bit_pos;
    logic [ACC_W-1:0]          x_placed;
    alu_types_pkg::alu_data_t  product;

    // mode decode, spare code falls into max
    always_comb begin
        is_frac = 1'b0;
        is_max  = 1'b0;
        case (alu_types_pkg::mul_mode_e'(bus.mode))
            alu_types_pkg::mul_pure: is_frac = 1'b0;
            alu_types_pkg::mul_frac: is_frac = 1'b1;
            alu_types_pkg::mul_max:  is_max  = 1'b1;
            default:                 is_max  = 1'b1;
        endcase
    end

    assign load     = (state == alu_state_pkg::mul_idle) && bus.start;
    assign iterate  = (state == alu_state_pkg::mul_run) && (cnt != '0);
    assign bit_pos  = FRAC_STEPS - cnt;                    // 0 on the first step
    assign x_placed = {{`ALU_FRAC_W{1'b0}}, x_q} << bit_pos;
    // drop the fraction bits, wraps to 13 bits
    assign product  = acc[ACC_W-1:`ALU_FRAC_W] + (add_x ? x_q : '0);

    //////////////////////////////////////////////////
    // sequencing
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state    <= alu_state_pkg::mul_idle;
            cnt      <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else if (!bus.start) begin          // start low returns to idle
            state    <= alu_state_pkg::mul_idle;
            cnt      <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            case (state)
                alu_state_pkg::mul_idle: begin
                    state <= alu_state_pkg::mul_run;
                    cnt   <= is_max ? '0 : FRAC_STEPS;    // max goes straight to finish
                end
                alu_state_pkg::mul_run: begin
                    if (iterate) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        result_q <= product;
                        done_q   <= 1'b1;
                        state    <= alu_state_pkg::mul_done;
                    end
                end
                alu_state_pkg::mul_done: done_q <= 1'b1;  // hold
                default: state <= alu_state_pkg::mul_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // datapath
    always_ff @(posedge CLK) begin
        if (load) begin
            x_q    <= bus.x;
            frac_q <= bus.y[`ALU_FRAC_W-1:0];
            add_x  <= is_frac;
            // 2x placed above the fraction, top bit of x is lost
            acc    <= is_max ? {bus.x[`ALU_DATA_W-2:0], 1'b0, {`ALU_FRAC_W{1'b0}}} : '0;
        end else if (iterate) begin
            if (frac_q[0]) begin
                acc <= acc + x_placed;
            end
            frac_q <= frac_q >> 1;
        end
    end

    assign bus.result = result_q;
    assign bus.done   = done_q;

    // done only follows an edge that saw start
    a_done_after_start: assert property (@(posedge CLK) disable iff (!RST_N)
        bus.done |-> $past(bus.start))
        else $error("multiplier done without start");

    a_done_state: assert property (@(posedge CLK) disable iff (!RST_N)
        bus.done |-> state == alu_state_pkg::mul_done)
        else $error("multiplier done outside mul_done");

endmodule

// File: source/restoring_divider.sv
//////////////////////////////////////////////////
// restoring divider giving a saturating 9-bit quotient
// mode picks the left shift of x before dividing by y
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "alu_consts.svh"

module restoring_divider (
    input  logic     CLK,
    input  logic     RST_N,
    alu_unit_if.unit bus
);
    localparam int WORK_W = `ALU_DATA_W + `ALU_QUOT_W;  // remainder above quotient
    localparam logic [`ALU_CNT_W-1:0] QUOT_STEPS = `ALU_QUOT_W;

    alu_state_pkg::div_state_e state;
    logic [`ALU_CNT_W-1:0]     cnt;
    logic                      done_q;
    alu_types_pkg::alu_data_t  result_q;

    alu_types_pkg::alu_data_t  y_q;        // divisor copy
    // upper part is the partial remainder, lower part shifts dividend out and quotient in
    logic [WORK_W-1:0]         work;

    logic                      load;
    logic                      iterate;
    logic                      saturate;
    alu_types_pkg::alu_data_t  rem_init;   // shifted dividend above bit 9, also x >> k
    logic [`ALU_QUOT_W-1:0]    low_init;   // shifted dividend bits 8..0
    logic [`ALU_DATA_W:0]      trial;      // remainder with next dividend bit
    logic [`ALU_DATA_W:0]      diff;
    logic                      fits;
    alu_types_pkg::alu_quot_t  quot;

    //////////////////////////////////////////////////
    // split of x << s, with s = 8, 7 or 6
    always_comb begin
        case (alu_types_pkg::div_mode_e'(bus.mode))
            alu_types_pkg::div_t27: begin
                rem_init = bus.x >> 2;
                low_init = {bus.x[1:0], 7'b0};
            end
            alu_types_pkg::div_t36: begin
                rem_init = bus.x >> 3;
                low_init = {bus.x[2:0], 6'b0};
            end
            alu_types_pkg::div_sa: begin
                rem_init = bus.x >> 1;
                low_init = {bus.x[0], 8'b0};
            end
            default: begin                      // spare code runs as sa
                rem_init = bus.x >> 1;
                low_init = {bus.x[0], 8'b0};
            end
        endcase
    end

    // quotient would not fit in 9 bits, y = 0 lands here too
    assign saturate = (rem_init >= bus.y);

    assign load    = (state == alu_state_pkg::div_idle) && bus.start;
    assign iterate = (state == alu_state_pkg::div_run) && (cnt != '0);
    assign trial   = {work[WORK_W-1:`ALU_QUOT_W], work[`ALU_QUOT_W-1]};
    assign diff    = trial - {1'b0, y_q};
    assign fits    = (trial >= {1'b0, y_q});
    assign quot    = work[`ALU_QUOT_W-1:0];

    //////////////////////////////////////////////////
    // sequencing
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state    <= alu_state_pkg::div_idle;
            cnt      <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else if (!bus.start) begin
            state    <= alu_state_pkg::div_idle;
            cnt      <= '0;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            case (state)
                alu_state_pkg::div_idle: begin
                    state <= alu_state_pkg::div_run;
                    cnt   <= saturate ? '0 : QUOT_STEPS;   // saturation skips the steps
                end
                alu_state_pkg::div_run: begin
                    if (iterate) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        result_q <= {{(`ALU_DATA_W-`ALU_QUOT_W){1'b0}}, quot};
                        done_q   <= 1'b1;
                        state    <= alu_state_pkg::div_done;
                    end
                end
                alu_state_pkg::div_done: done_q <= 1'b1;
                default: state <= alu_state_pkg::div_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // datapath, one quotient bit per step msb first
    always_ff @(posedge CLK) begin
        if (load) begin
            y_q  <= bus.y;
            work <= saturate ? {{`ALU_DATA_W{1'b0}}, {`ALU_QUOT_W{1'b1}}}
                             : {rem_init, low_init};
        end else if (iterate) begin
            if (fits) begin
                work <= {diff[`ALU_DATA_W-1:0], work[`ALU_QUOT_W-2:0], 1'b1};  // subtract
            end else begin
                work <= {trial[`ALU_DATA_W-1:0], work[`ALU_QUOT_W-2:0], 1'b0}; // restore
            end
        end
    end

    assign bus.result = result_q;
    assign bus.done   = done_q;

    a_done_after_start: assert property (@(posedge CLK) disable iff (!RST_N)
        bus.done |-> $past(bus.start))
        else $error("divider done without start");

    a_cnt_range: assert property (@(posedge CLK) disable iff (!RST_N)
        cnt <= QUOT_STEPS)
        else $error("divider step count above 9");

endmodule

// File: source/super_alu.sv
//////////////////////////////////////////////////
// shared fixed-point ALU, multiply or divide on request
// hold alu_start until alu_is_done, read fout, then drop it
//////////////////////////////////////////////////

`timescale 1ns/1ps

module super_alu (
    input  logic                      CLK,
    input  logic                      RST_N,
    input  alu_types_pkg::alu_data_t  x_in,        // multiplicand or dividend
    input  alu_types_pkg::alu_data_t  y_in,        // fraction or divisor
    input  logic                      alu_start,   // level, held for the whole operation
    input  alu_types_pkg::alu_op_e    alu_type,
    input  alu_types_pkg::alu_mode_t  mode_type,
    output alu_types_pkg::alu_data_t  fout,
    output logic                      alu_is_done
);

    // one link per arithmetic unit
    alu_unit_if mul_bus (
        .CLK   (CLK),
        .RST_N (RST_N)
    );

    alu_unit_if div_bus (
        .CLK   (CLK),
        .RST_N (RST_N)
    );

    alu_dispatch u_dispatch (
        .alu_start   (alu_start),
        .alu_type    (alu_type),
        .mode_type   (mode_type),
        .x_in        (x_in),
        .y_in        (y_in),
        .mul_bus     (mul_bus.ctrl),
        .div_bus     (div_bus.ctrl),
        .fout        (fout),
        .alu_is_done (alu_is_done)
    );

    frac_multiplier u_mul (
        .CLK   (CLK),
        .RST_N (RST_N),
        .bus   (mul_bus.unit)
    );

    restoring_divider u_div (
        .CLK   (CLK),
        .RST_N (RST_N),
        .bus   (div_bus.unit)
    );

endmodule

// File: verification/alu_ref_model.svh
//////////////////////////////////////////////////
// random source and reference model of the ALU testbench
// included inside the testbench module
//////////////////////////////////////////////////

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// one step of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

//////////////////////////////////////////////////
// multiply, y is an 8-bit binary fraction
function automatic alu_types_pkg::alu_data_t mul_model(
    input alu_types_pkg::alu_data_t x,
    input alu_types_pkg::alu_data_t y,
    input alu_types_pkg::alu_mode_t mode
);
    logic [31:0] prod;      // exact x*y, no rounding
    logic [31:0] sum;
    prod = {19'd0, x} * {24'd0, y[7:0]};
    if (mode == 2'd2 || mode == 2'd3) begin
        sum = {19'd0, x} << 1;          // max, code 3 the same
    end else begin
        sum = prod >> 8;                // floor(x*y/256)
        if (mode == 2'd1) begin
            sum = sum + {19'd0, x};     // frac adds x back
        end
    end
    return sum[12:0];                   // modulo 2^13
endfunction

//////////////////////////////////////////////////
// divide (x << s) by y, 9-bit quotient, all ones on overflow
function automatic alu_types_pkg::alu_data_t div_model(
    input alu_types_pkg::alu_data_t x,
    input alu_types_pkg::alu_data_t y,
    input alu_types_pkg::alu_mode_t mode
);
    int unsigned shift;
    int unsigned dividend;
    int unsigned quot;
    case (mode)
        2'd1:    shift = 7;
        2'd2:    shift = 6;
        default: shift = 8;             // sa, and code 3
    endcase
    dividend = {19'd0, x} << shift;
    if (y == '0) begin
        return 13'd511;                 // divide by zero
    end
    quot = dividend / {19'd0, y};
    if (quot > 511) begin
        return 13'd511;                 // needs a tenth bit
    end
    return alu_types_pkg::alu_data_t'(quot);
endfunction

// largest y that still saturates, x/2, x/4 or x/8 by mode
function automatic int unsigned sat_bound(
    input alu_types_pkg::alu_data_t x,
    input alu_types_pkg::alu_mode_t mode
);
    case (mode)
        2'd1:    return {19'd0, x} >> 2;
        2'd2:    return {19'd0, x} >> 3;
        default: return {19'd0, x} >> 1;
    endcase
endfunction

`endif

// File: verification/super_alu_tb.sv
//////////////////////////////////////////////////
// self-checking random testbench of the shared ALU
// multiply and divide against the included model, then dead op codes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module super_alu_tb;

    localparam int MAX_EDGES   = 12;                       // latency bound
    localparam int N_MUL       = 40;
    localparam int N_DIV       = 60;
    localparam int N_TXN       = N_MUL + 16 + N_DIV + 16 + 5;
    localparam int WATCHDOG_NS = N_TXN * 16 * 10 + 1000;   // 16 cycles each plus margin

    logic                     CLK = 1'b0;
    logic                     RST_N;
    alu_types_pkg::alu_data_t x_in;
    alu_types_pkg::alu_data_t y_in;
    logic                     alu_start;
    alu_types_pkg::alu_op_e   alu_type;
    alu_types_pkg::alu_mode_t mode_type;
    alu_types_pkg::alu_data_t fout;
    logic                     alu_is_done;

    logic [31:0] rng_state;
    int          err_count;
    int          check_count;
    int          test_count;
    int          test_fails;

    `include "alu_ref_model.svh"

    super_alu dut (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .x_in        (x_in),
        .y_in        (y_in),
        .alu_start   (alu_start),
        .alu_type    (alu_type),
        .mode_type   (mode_type),
        .fout        (fout),
        .alu_is_done (alu_is_done)
    );

    always #5 CLK = ~CLK;   // 10 ns

    // next value below n, from the upper lcg bits
    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = lcg_step(rng_state);
        return (rng_state >> 8) % n;
    endfunction

    //////////////////////////////////////////////////
    // compares
    task automatic check_data(input string name, input alu_types_pkg::alu_data_t exp_val,
                              input alu_types_pkg::alu_data_t act_val);
        check_count++;
        if (act_val !== exp_val) begin
            err_count++;
            $display("error at %0t ns: %s expected %0d, actual %0d",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_done(input bit exp_val, input logic act_val);
        check_count++;
        if (act_val !== exp_val) begin
            err_count++;
            $display("error at %0t ns: alu_is_done expected %b, actual %b",
                     $time, exp_val, act_val);
        end
    endtask

    //////////////////////////////////////////////////
    // one request held until done, then dropped and the clear checked
    task automatic run_op(input alu_types_pkg::alu_op_e op, input alu_types_pkg::alu_mode_t mode,
                          input alu_types_pkg::alu_data_t x, input alu_types_pkg::alu_data_t y,
                          input alu_types_pkg::alu_data_t exp_val);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        @(posedge CLK);
        x_in      <= x;
        y_in      <= y;
        mode_type <= mode;
        alu_type  <= op;
        alu_start <= 1'b1;
        while (!seen && edges < MAX_EDGES) begin
            @(posedge CLK);
            edges++;
            @(negedge CLK);     // outputs settled
            seen = alu_is_done;
        end
        if (seen) begin
            check_data("fout", exp_val, fout);
        end else begin
            err_count++;
            $display("no done from the ALU within %0d clock edges (op %b, mode %0d, x %0d, y %0d)",
                     MAX_EDGES, op, mode, x, y);
        end
        @(posedge CLK);
        alu_start <= 1'b0;
        @(posedge CLK);         // first edge with start low
        @(negedge CLK);
        check_done(1'b0, alu_is_done);
        check_data("fout", '0, fout);
    endtask

    // a code that must start nothing, held for the full latency bound
    task automatic hold_unstarted(input alu_types_pkg::alu_op_e op);
        int i;
        @(posedge CLK);
        x_in      <= alu_types_pkg::alu_data_t'(rand_below(8192));
        y_in      <= alu_types_pkg::alu_data_t'(rand_below(8192));
        mode_type <= alu_types_pkg::alu_mode_t'(rand_below(4));
        alu_type  <= op;
        alu_start <= 1'b1;
        for (i = 0; i < MAX_EDGES; i++) begin
            @(posedge CLK);
            @(negedge CLK);
            check_done(1'b0, alu_is_done);
            check_data("fout", '0, fout);
        end
        @(posedge CLK);
        alu_start <= 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        check_done(1'b0, alu_is_done);
        check_data("fout", '0, fout);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int                       i;
        int                       base;
        int unsigned              lim;
        alu_types_pkg::alu_data_t x;
        alu_types_pkg::alu_data_t y;
        alu_types_pkg::alu_mode_t m;

        rng_state   = 32'h220e;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_fails  = 0;
        RST_N     <= 1'b0;
        alu_start <= 1'b0;
        alu_type  <= alu_types_pkg::op_mul;
        mode_type <= 2'd0;
        x_in      <= '0;
        y_in      <= '0;
        repeat (3) @(posedge CLK);
        RST_N <= 1'b1;

        base = err_count;
        @(negedge CLK);
        check_done(1'b0, alu_is_done);
        check_data("fout", '0, fout);
        report_test("idle after reset", base);

        base = err_count;
        for (i = 0; i < N_MUL; i++) begin
            x = alu_types_pkg::alu_data_t'(rand_below(8192));
            y = alu_types_pkg::alu_data_t'(rand_below(256));   // 8-bit fraction
            m = alu_types_pkg::alu_mode_t'(i % 2);             // pure, frac
            run_op(alu_types_pkg::op_mul, m, x, y, mul_model(x, y, m));
        end
        report_test("multiply pure and frac", base);

        base = err_count;
        for (i = 0; i < 16; i++) begin
            x = alu_types_pkg::alu_data_t'(rand_below(8192));
            y = alu_types_pkg::alu_data_t'(rand_below(8192));  // ignored in max
            m = alu_types_pkg::alu_mode_t'(2 + i % 2);
            run_op(alu_types_pkg::op_mul, m, x, y, mul_model(x, y, m));
        end
        report_test("multiply max and mode 3", base);

        base = err_count;
        for (i = 0; i < N_DIV; i++) begin
            x   = alu_types_pkg::alu_data_t'(rand_below(8192));
            m   = alu_types_pkg::alu_mode_t'(i % 4);
            lim = sat_bound(x, m);
            if (rand_below(2) == 0) begin
                y = alu_types_pkg::alu_data_t'(lim + 1 + rand_below(8191 - lim));  // fits
            end else begin
                y = alu_types_pkg::alu_data_t'(rand_below(lim + 1));
            end
            run_op(alu_types_pkg::op_div, m, x, y, div_model(x, y, m));
        end
        report_test("divide mixed", base);

        base = err_count;
        for (i = 0; i < 16; i++) begin
            m   = alu_types_pkg::alu_mode_t'(i % 4);
            x   = (i < 4) ? '0 : alu_types_pkg::alu_data_t'(rand_below(8192));
            lim = sat_bound(x, m);
            case (i / 4)
                0, 1:    y = '0;                                   // zero divisor
                2:       y = alu_types_pkg::alu_data_t'(lim);      // on the boundary
                default: y = alu_types_pkg::alu_data_t'(rand_below(lim + 1));
            endcase
            run_op(alu_types_pkg::op_div, m, x, y, div_model(x, y, m));
        end
        report_test("divide saturating", base);

        base = err_count;
        hold_unstarted(alu_types_pkg::op_sqrt);
        hold_unstarted(alu_types_pkg::alu_op_e'(3'b000));
        hold_unstarted(alu_types_pkg::alu_op_e'(3'b011));
        hold_unstarted(alu_types_pkg::alu_op_e'(3'b110));
        hold_unstarted(alu_types_pkg::alu_op_e'(3'b111));
        report_test("unstarted op codes", base);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

endmodule
